// ==== uart_rx.f ====
+incdir+design
design/uart_pkg.sv
design/rx_frame.sv
design/parity_tracker.sv
design/rx_result.sv
design/uart_rx_top.sv
verif/tb_clock.sv
verif/rx_checker.sv
verif/uart_rx_asserts.sv
verif/uart_rx_tb.sv

// ==== Bender.yml ====
package:
  name: uart_rx

sources:
  - include_dirs:
      - design
    files:
      - design/uart_pkg.sv
      - design/rx_frame.sv
      - design/parity_tracker.sv
      - design/rx_result.sv
      - design/uart_rx_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - verif/tb_clock.sv
      - verif/rx_checker.sv
      - verif/uart_rx_asserts.sv
      - verif/uart_rx_tb.sv

// ==== verif/uart_rx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_consts.svh"

module uart_rx_tb
    import uart_pkg::*;
();

    localparam int cpb       = `UART_CLKS_PER_BIT;
    localparam int n_frames  = 200 + 20 + 20 + 10 + 30;
    localparam int n_glitch  = 10;
    localparam int glitch_len = (cpb / 4 > 1) ? cpb / 4 - 1 : 1;  // Under a quarter bit
    // Twice the worst case for all frames with their gaps and the glitches
    localparam int unsigned cycle_limit =
        2 * (n_frames * 11 * cpb + n_frames * 4 * cpb + n_glitch * 3 * cpb + 40 * cpb);

    logic        clk;
    logic        reset;
    logic        rx;
    byte_t       data;
    logic        byte_valid;
    logic        parity_error;
    logic        framing_error;
    err_count_t  parity_err_count;
    err_count_t  frame_err_count;
    logic [31:0] rng;
    int unsigned cycle_count;

    tb_clock clock_gen (.clk(clk));

    uart_rx_top uut (
        .clk              (clk),
        .reset            (reset),
        .rx               (rx),
        .data             (data),
        .byte_valid       (byte_valid),
        .parity_error     (parity_error),
        .framing_error    (framing_error),
        .parity_err_count (parity_err_count),
        .frame_err_count  (frame_err_count)
    );

    rx_checker chk (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Each call starts and ends on a falling edge
    task automatic send_bit(input logic b);
        rx = b;
        repeat (cpb) @(negedge clk);
    endtask

    task automatic send_frame(input byte_t d, input bit bad_par, input bit bad_stop,
                              input int gap_bits);
        logic par;
        par = (^d) ^ bad_par;  // Even parity over data and parity bit
        chk.push_expect(d, bad_par, bad_stop);
        send_bit(1'b0);
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            send_bit(d[i]);
        end
        send_bit(par);
        send_bit(!bad_stop);
        if (bad_stop) begin
            send_bit(1'b1);  // Line back high before the next start
        end
        repeat (gap_bits) send_bit(1'b1);
    endtask

    // kind 0 clean, 1 bad parity, 2 bad stop with random parity, 3 clean without gap
    task automatic send_random(input int count, input int kind);
        byte_t d;
        bit    bad_par;
        int    gap;
        for (int n = 0; n < count; n++) begin
            rng = lcg_next(rng);
            d = rng[23:16];
            rng = lcg_next(rng);
            bad_par = (kind == 1) || (kind == 2 && rng[20]);
            rng = lcg_next(rng);
            gap = (kind == 3) ? 0 : int'(rng[25:24]);
            send_frame(d, bad_par, kind == 2, gap);
        end
    endtask

    task automatic send_glitch();
        rx = 1'b0;
        repeat (glitch_len) @(negedge clk);
        rx = 1'b1;
        repeat (2 * cpb) @(negedge clk);  // Let the start check reject it
    endtask

    task automatic finish_test(input string name);
        chk.wait_drained();
        repeat (2 * cpb) @(negedge clk);  // Catch any late extra byte
        chk.report_test(name);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout, run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        cycle_count = 0;
        rng   = 32'd38770;
        reset = 1'b1;
        rx    = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        chk.check_reset_state();
        chk.report_test("reset state");
        send_random(200, 0);
        finish_test("clean frames");
        send_random(20, 1);
        finish_test("parity errors");
        send_random(20, 2);
        finish_test("framing errors");
        for (int g = 0; g < n_glitch; g++) begin
            send_glitch();
            send_random(1, 0);
        end
        finish_test("line glitches");
        send_random(30, 3);
        finish_test("back to back");

        $display("total %0d checks, %0d errors, %0d assertion failures",
                 chk.checks, chk.errors, uut.u_asserts.fail_count);
        if (chk.errors == 0 && uut.u_asserts.fail_count == 0
                && chk.exp_data_q.size() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/uart_rx_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx_asserts
    import uart_pkg::*;
(
    input wire        clk,
    input wire        reset,
    input wire        byte_valid,
    input wire        parity_error,
    input wire        framing_error,
    input err_count_t parity_err_count,
    input err_count_t frame_err_count
);

    int unsigned fail_count = 0;  // Failed assertions so far

    // Strobe lasts exactly one cycle
    valid_single: assert property (@(posedge clk) disable iff (reset)
        byte_valid |=> !byte_valid)
        else begin
            fail_count++;
            $error("byte_valid high for two cycles");
        end

    // Flags are loaded together with the strobe
    perr_flag_only_with_valid: assert property (@(posedge clk) disable iff (reset)
        !$stable(parity_error) |-> byte_valid)
        else begin
            fail_count++;
            $error("parity_error changed without byte_valid");
        end

    ferr_flag_only_with_valid: assert property (@(posedge clk) disable iff (reset)
        !$stable(framing_error) |-> byte_valid)
        else begin
            fail_count++;
            $error("framing_error changed without byte_valid");
        end

    perr_count_step: assert property (@(posedge clk) disable iff (reset)
        !$stable(parity_err_count) |-> byte_valid && parity_error)
        else begin
            fail_count++;
            $error("parity_err_count changed without a parity error");
        end

    ferr_count_step: assert property (@(posedge clk) disable iff (reset)
        !$stable(frame_err_count) |-> byte_valid && framing_error)
        else begin
            fail_count++;
            $error("frame_err_count changed without a framing error");
        end

endmodule

bind uart_rx_top uart_rx_asserts u_asserts (.*);

`default_nettype wire

// ==== verif/rx_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_consts.svh"

module rx_checker
    import uart_pkg::*;
(
    input wire        clk,
    input wire        reset,
    input byte_t      data,
    input wire        byte_valid,
    input wire        parity_error,
    input wire        framing_error,
    input err_count_t parity_err_count,
    input err_count_t frame_err_count
);

    // A byte must show up within two frame times of its start bit
    localparam int unsigned window = 2 * 11 * `UART_CLKS_PER_BIT;

    byte_t       exp_data_q[$];
    bit          exp_perr_q[$];
    bit          exp_ferr_q[$];
    int unsigned exp_cycle_q[$];
    int unsigned cycle;
    err_count_t  model_perr_cnt;
    err_count_t  model_ferr_cnt;
    int          checks;
    int          errors;
    int          mark_checks;
    int          mark_errors;

    initial begin
        cycle          = 0;
        model_perr_cnt = '0;
        model_ferr_cnt = '0;
        checks         = 0;
        errors         = 0;
        mark_checks    = 0;
        mark_errors    = 0;
    end

    // Called by the driver when a frame goes out on the line
    task automatic push_expect(input byte_t d, input bit perr, input bit ferr);
        exp_data_q.push_back(d);
        exp_perr_q.push_back(perr);
        exp_ferr_q.push_back(ferr);
        exp_cycle_q.push_back(cycle);
    endtask

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_reset_state();
        compare("byte_valid", {7'd0, byte_valid}, 8'h00);
        compare("parity_error", {7'd0, parity_error}, 8'h00);
        compare("framing_error", {7'd0, framing_error}, 8'h00);
        compare("data", data, 8'h00);
        compare("parity_err_count", parity_err_count, 8'h00);
        compare("frame_err_count", frame_err_count, 8'h00);
    endtask

    task automatic wait_drained();
        while (exp_data_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %-16s %0d checks, %0d errors", name,
                 checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // Outputs are registered, so the falling edge sees settled values
    always @(negedge clk) begin
        cycle++;
        if (!reset && byte_valid) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("Unexpected byte 0x%02h received with no frame pending", data);
            end else begin
                if (exp_perr_q[0]) model_perr_cnt++;  // Wraps like the DUT
                if (exp_ferr_q[0]) model_ferr_cnt++;
                compare("data", data, exp_data_q[0]);
                compare("parity_error", {7'd0, parity_error}, {7'd0, exp_perr_q[0]});
                compare("framing_error", {7'd0, framing_error}, {7'd0, exp_ferr_q[0]});
                compare("parity_err_count", parity_err_count, model_perr_cnt);
                compare("frame_err_count", frame_err_count, model_ferr_cnt);
                void'(exp_data_q.pop_front());
                void'(exp_perr_q.pop_front());
                void'(exp_ferr_q.pop_front());
                void'(exp_cycle_q.pop_front());
            end
        end else if (exp_cycle_q.size() != 0 && cycle - exp_cycle_q[0] > window) begin
            errors++;
            $display("Expected byte 0x%02h never arrived", exp_data_q[0]);
            void'(exp_data_q.pop_front());
            void'(exp_perr_q.pop_front());
            void'(exp_ferr_q.pop_front());
            void'(exp_cycle_q.pop_front());
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 40 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #20 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== design/uart_rx_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx_top
    import uart_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        rx,
    output byte_t      data,
    output logic       byte_valid,
    output logic       parity_error,
    output logic       framing_error,
    output err_count_t parity_err_count,
    output err_count_t frame_err_count
);

    logic  sample_strobe;
    logic  sample_bit;
    logic  frame_start;
    logic  frame_end;
    logic  stop_ok;
    logic  parity_odd;
    byte_t frame_data;

    // Bit timing and frame sequencing
    rx_frame u_frame (
        .clk           (clk),
        .reset         (reset),
        .rx            (rx),
        .sample_strobe (sample_strobe),
        .sample_bit    (sample_bit),
        .frame_start   (frame_start),
        .frame_end     (frame_end),
        .stop_ok       (stop_ok),
        .frame_data    (frame_data)
    );

    parity_tracker u_parity (
        .clk           (clk),
        .reset         (reset),
        .frame_start   (frame_start),
        .sample_strobe (sample_strobe),
        .sample_bit    (sample_bit),
        .parity_odd    (parity_odd)
    );

    // Registered byte, flags and counters
    rx_result u_result (
        .clk              (clk),
        .reset            (reset),
        .frame_end        (frame_end),
        .stop_ok          (stop_ok),
        .parity_odd       (parity_odd),
        .frame_data       (frame_data),
        .data             (data),
        .byte_valid       (byte_valid),
        .parity_error     (parity_error),
        .framing_error    (framing_error),
        .parity_err_count (parity_err_count),
        .frame_err_count  (frame_err_count)
    );

endmodule

`default_nettype wire

// ==== design/rx_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module rx_result
    import uart_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        frame_end,
    input  wire        stop_ok,
    input  wire        parity_odd,
    input  byte_t      frame_data,
    output byte_t      data,
    output logic       byte_valid,
    output logic       parity_error,
    output logic       framing_error,
    output err_count_t parity_err_count,
    output err_count_t frame_err_count
);

    // Result registers, loaded once per frame
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data          <= '0;
            byte_valid    <= 1'b0;
            parity_error  <= 1'b0;
            framing_error <= 1'b0;
        end else begin
            byte_valid <= frame_end;  // One-cycle strobe
            if (frame_end) begin
                data          <= frame_data;
                parity_error  <= parity_odd;  // Odd total breaks even parity
                framing_error <= ~stop_ok;
            end
        end
    end

    // Error counters wrap at 256
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            parity_err_count <= '0;
            frame_err_count  <= '0;
        end else if (frame_end) begin
            if (parity_odd) begin
                parity_err_count <= parity_err_count + 1'b1;
            end
            if (!stop_ok) begin
                frame_err_count <= frame_err_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/parity_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module parity_tracker (
    input  wire  clk,
    input  wire  reset,
    input  wire  frame_start,
    input  wire  sample_strobe,
    input  wire  sample_bit,
    output logic parity_odd
);

    // Running XOR of every strobed bit in the current frame.
    // With even parity the total over data and parity bits should be 0.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            parity_odd <= 1'b0;
        end else if (frame_start) begin
            parity_odd <= 1'b0;          // New frame
        end else if (sample_strobe && sample_bit) begin
            parity_odd <= ~parity_odd;
        end
    end

endmodule

`default_nettype wire

// ==== design/rx_frame.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_consts.svh"

module rx_frame
    import uart_pkg::*;
(
    input  wire   clk,
    input  wire   reset,
    input  wire   rx,
    output logic  sample_strobe,
    output logic  sample_bit,
    output logic  frame_start,
    output logic  frame_end,
    output logic  stop_ok,
    output byte_t frame_data
);

    // Sample points inside a bit time
    localparam bit_count_t half_bit = bit_count_t'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam bit_count_t full_bit = bit_count_t'(`UART_CLKS_PER_BIT - 1);
    localparam bit_index_t last_bit = bit_index_t'(`UART_DATA_BITS - 1);

    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic       fall;
    logic       mid_start;
    logic       bit_done;
    rx_state_t  state;
    bit_count_t bit_cnt;
    bit_index_t bit_idx;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;  // Edge detect only
        end
    end

    assign fall      = rx_prev & ~rx_sync;
    assign mid_start = (state == st_start) && (bit_cnt == half_bit);
    assign bit_done  = (state != st_start) && (bit_cnt == full_bit);

    // Bit-time counter, restarts at every sample point
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_cnt <= '0;
        end else if (state == st_idle || mid_start || bit_done) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Frame state machine
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= st_idle;
            bit_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (fall) begin
                        state <= st_start;
                    end
                end

                st_start: begin
                    if (mid_start) begin
                        if (!rx_sync) begin
                            state   <= st_data;
                            bit_idx <= '0;
                        end else begin
                            state <= st_idle;  // Glitch, drop the frame
                        end
                    end
                end

                st_data: begin
                    if (bit_done) begin
                        if (bit_idx == last_bit) begin
                            state <= st_parity;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end

                st_parity: begin
                    if (bit_done) begin
                        state <= st_stop;
                    end
                end

                st_stop: begin
                    // Back to idle at mid stop bit, ready for the next edge
                    if (bit_done) begin
                        state <= st_idle;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Strobes to the parity tracker and the result stage
    always_comb begin
        frame_start   = mid_start && !rx_sync;
        sample_strobe = bit_done && (state == st_data || state == st_parity);
        frame_end     = bit_done && (state == st_stop);
    end

    assign sample_bit = rx_sync;
    assign stop_ok    = rx_sync;  // Only meaningful with frame_end

    // Data shift register, LSB arrives first
    always_ff @(posedge clk) begin
        if (bit_done && state == st_data) begin
            frame_data <= {rx_sync, frame_data[`UART_DATA_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== design/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

`include "uart_consts.svh"

    typedef logic [`UART_DATA_BITS-1:0] byte_t;      // Received data word
    typedef logic [7:0]                 err_count_t; // Wraps at 256
    typedef logic [`UART_CNT_WIDTH-1:0] bit_count_t; // Position inside one bit time
    typedef logic [2:0]                 bit_index_t; // Current data bit

    // Receiver frame states
    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop
    } rx_state_t;

endpackage

`default_nettype wire

// ==== design/uart_consts.svh ====
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Clock cycles per serial bit, even and at least 4
`define UART_CLKS_PER_BIT 16

// Width of the bit-time counter
`define UART_CNT_WIDTH 8

// Data bits per frame, LSB first on the line
`define UART_DATA_BITS 8

`endif
